// File: Makefile
SIM := obj_dir/Vhost_io_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): host_io_top.f include/host_params.svh verilog/*.sv tb/host_io_tb.sv
	verilator --binary --timing --assert -Wno-fatal --top-module host_io_tb \
		-f host_io_top.f -o Vhost_io_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: host_io_top.f
+incdir+include
verilog/host_io_pkg.sv
verilog/host_perf_pkg.sv
verilog/host_cmd_decode.sv
verilog/host_cfg_regs.sv
verilog/host_perf_counters.sv
verilog/host_watchdog.sv
verilog/host_io_top.sv
tb/host_io_tb.sv

// File: include/host_params.svh
`ifndef HOST_PARAMS_SVH
`define HOST_PARAMS_SVH

// Command and response data width
`define HOST_DATA_W 32

// Register address width
`define HOST_ADDR_W 4

// Number of mapped registers, addresses 0 up to HOST_REG_CNT-1
`define HOST_REG_CNT 6

// Trace enable bits held by the host
`define HOST_TRACE_W 8

// Commit-free cycles before the watchdog trips
`define HOST_STALL_LIMIT 64

`endif

// File: tb/host_io_tb.sv
`timescale 1ns/1ps

`include "host_params.svh"

module host_io_tb;

  localparam int MODE_CFG = 0;
  localparam int MODE_ERR = 1;
  localparam int MODE_CNT = 2;
  localparam int MODE_FIN = 3;

  localparam int CFG_CYCLES   = 200;
  localparam int ERR_CYCLES   = 200;
  localparam int CNT_CYCLES   = 600;
  localparam int FIN_CYCLES   = 200;
  localparam int RST_CYCLES   = 5;
  localparam int STALL_CYCLES = `HOST_STALL_LIMIT + 4;
  localparam int RUN_CYCLES   = CFG_CYCLES + ERR_CYCLES + CNT_CYCLES + FIN_CYCLES
                              + 2 * RST_CYCLES + STALL_CYCLES + 20;
  // Roughly twice the whole run
  localparam int MAX_CYCLES   = 2 * RUN_CYCLES + 400;

  logic                          clk;
  logic                          rst_n;
  logic                          cmd_v;
  host_io_pkg::host_op_e         cmd_op;
  host_io_pkg::host_addr_e       cmd_addr;
  logic [`HOST_DATA_W-1:0]       cmd_data;
  logic                          commit_v;
  logic                          resp_v;
  logic [`HOST_DATA_W-1:0]       resp_data;
  logic                          resp_err;
  logic [`HOST_TRACE_W-1:0]      trace_en;
  logic                          profile_en;
  logic                          finish;
  logic                          pass;
  logic                          stall;

  // Reference model state
  logic [`HOST_TRACE_W-1:0]      m_trace;
  logic                          m_profile;
  logic                          m_finish;
  logic                          m_pass;
  host_perf_pkg::perf_cnt_t      m_cycle;
  host_perf_pkg::perf_cnt_t      m_instret;
  host_perf_pkg::wd_state_e      m_wd;
  int                            m_idle;
  logic                          m_stall;

  // Expected response for the command of the last edge
  logic                          e_resp_v;
  logic                          e_resp_err;
  logic [`HOST_DATA_W-1:0]       e_resp_data;
  logic                          e_wd_load;
  host_perf_pkg::wd_state_e      e_wd;

  logic [31:0]                   rng;
  string                         test_name;
  int                            chk_cnt;
  int                            err_cnt;

  host_io_top host_io_top_inst
    (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .cmd_v_i      (cmd_v),
      .cmd_op_i     (cmd_op),
      .cmd_addr_i   (cmd_addr),
      .cmd_data_i   (cmd_data),
      .resp_v_o     (resp_v),
      .resp_data_o  (resp_data),
      .resp_err_o   (resp_err),
      .commit_v_i   (commit_v),
      .trace_en_o   (trace_en),
      .profile_en_o (profile_en),
      .finish_o     (finish),
      .pass_o       (pass),
      .stall_o      (stall)
    );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_word(input string what, input host_perf_pkg::perf_cnt_t exp,
                            input host_perf_pkg::perf_cnt_t act);
    chk_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("Error %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic expect_state(input string what, input host_perf_pkg::wd_state_e exp,
                              input host_perf_pkg::wd_state_e act);
    chk_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("Error %s: %s expected %s actual %s", test_name, what, exp.name(), act.name());
    end
  endtask

  task automatic compare_bit(input string what, input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("Error %s: %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic clear_model();
    m_trace   = '0;
    m_profile = 1'b0;
    m_finish  = 1'b0;
    m_pass    = 1'b0;
    m_cycle   = '0;
    m_instret = '0;
    m_wd      = host_perf_pkg::WD_ARMED;
    m_idle    = 0;
    m_stall   = 1'b0;
  endtask

  // One clock edge of the host using the inputs still on the pins
  task automatic advance_model();
    logic                    is_store;
    logic                    mapped;
    logic                    ro;
    logic [`HOST_DATA_W-1:0] rd;
    is_store = (cmd_op == host_io_pkg::OP_STORE);
    mapped   = (cmd_addr <= host_io_pkg::ADDR_WD_STATUS);
    ro       = (cmd_addr >= host_io_pkg::ADDR_CYCLE_CNT) && mapped;
    rd       = '0;
    case (cmd_addr)
      host_io_pkg::ADDR_TRACE_EN:    rd[`HOST_TRACE_W-1:0] = m_trace;
      host_io_pkg::ADDR_PROFILE_EN:  rd[0] = m_profile;
      host_io_pkg::ADDR_FINISH:      rd[1:0] = {m_pass, m_finish};
      host_io_pkg::ADDR_CYCLE_CNT:   rd = m_cycle;
      host_io_pkg::ADDR_INSTRET_CNT: rd = m_instret;
      host_io_pkg::ADDR_WD_STATUS:   rd[1:0] = m_wd;
      default:                       rd = '0;
    endcase
    e_resp_v    = cmd_v;
    e_resp_err  = cmd_v && (!mapped || (is_store && ro));
    e_resp_data = is_store ? '0 : rd;
    e_wd_load   = cmd_v && !is_store && (cmd_addr == host_io_pkg::ADDR_WD_STATUS);
    e_wd        = m_wd;
    if (m_profile && !m_finish)
    begin
      m_cycle = m_cycle + 1;
      if (commit_v)
      begin
        m_instret = m_instret + 1;
      end
    end
    if (m_wd == host_perf_pkg::WD_ARMED)
    begin
      if (m_finish)
      begin
        m_wd = host_perf_pkg::WD_FINISHED;
      end
      else if (commit_v)
      begin
        m_idle = 0;
      end
      else
      begin
        m_idle++;
        if (m_idle == `HOST_STALL_LIMIT)
        begin
          m_wd    = host_perf_pkg::WD_STALLED;
          m_stall = 1'b1;
        end
      end
    end
    if (cmd_v && is_store)
    begin
      case (cmd_addr)
        host_io_pkg::ADDR_TRACE_EN:   m_trace = cmd_data[`HOST_TRACE_W-1:0];
        host_io_pkg::ADDR_PROFILE_EN: m_profile = cmd_data[0];
        host_io_pkg::ADDR_FINISH:
        begin
          if (!m_finish)
          begin
            m_finish = 1'b1;
            m_pass   = cmd_data[0];
          end
        end
        default:;
      endcase
    end
  endtask

  task automatic go_idle();
    cmd_v    = 1'b0;
    cmd_op   = host_io_pkg::OP_LOAD;
    cmd_addr = host_io_pkg::ADDR_TRACE_EN;
    cmd_data = '0;
    commit_v = 1'b0;
  endtask

  task automatic send_cmd(input host_io_pkg::host_op_e op, input host_io_pkg::host_addr_e addr,
                          input logic [`HOST_DATA_W-1:0] data);
    cmd_v    = 1'b1;
    cmd_op   = op;
    cmd_addr = addr;
    cmd_data = data;
  endtask

  // Edge, model update, then compare every output
  task automatic tick();
    @(posedge clk);
    #1;
    advance_model();
    compare_bit("resp_v_o", e_resp_v, resp_v);
    compare_bit("resp_err_o", e_resp_err, resp_err);
    if (e_resp_v)
    begin
      check_word("resp_data_o", e_resp_data, resp_data);
    end
    if (e_wd_load)
    begin
      expect_state("wd_status", e_wd, host_perf_pkg::wd_state_e'(resp_data[1:0]));
    end
    check_word("trace_en_o", host_perf_pkg::perf_cnt_t'(m_trace),
               host_perf_pkg::perf_cnt_t'(trace_en));
    compare_bit("profile_en_o", m_profile, profile_en);
    compare_bit("finish_o", m_finish, finish);
    compare_bit("pass_o", m_pass, pass);
    compare_bit("stall_o", m_stall, stall);
  endtask

  task automatic random_stimulus(input int mode);
    logic [31:0]             r;
    logic [31:0]             d;
    host_io_pkg::host_addr_e a;
    host_io_pkg::host_op_e   op;
    r  = next_rand();
    d  = next_rand();
    op = host_io_pkg::host_op_e'(r[8]);
    a  = host_io_pkg::ADDR_TRACE_EN;
    case (mode)
      MODE_CFG:
        a = r[4] ? host_io_pkg::ADDR_PROFILE_EN : host_io_pkg::ADDR_TRACE_EN;
      MODE_ERR:
      begin
        a = host_io_pkg::host_addr_e'(r[7:4]);
        // Finish waits for its own phase
        if (a == host_io_pkg::ADDR_FINISH)
        begin
          op = host_io_pkg::OP_LOAD;
        end
      end
      default:
      begin
        case (r[5:4])
          2'd0: a = (mode == MODE_CNT) ? host_io_pkg::ADDR_PROFILE_EN : host_io_pkg::ADDR_FINISH;
          2'd1: a = host_io_pkg::ADDR_CYCLE_CNT;
          2'd2: a = host_io_pkg::ADDR_INSTRET_CNT;
          default: a = host_io_pkg::ADDR_WD_STATUS;
        endcase
        if (r[5:4] != 2'd0)
        begin
          op = host_io_pkg::OP_LOAD;
        end
      end
    endcase
    send_cmd(op, a, d);
    cmd_v    = r[1] | r[2];
    commit_v = r[0];
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    go_idle();
    clear_model();
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  initial
  begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the run did not complete", MAX_CYCLES);
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    rng       = 32'hd1edbd31;
    chk_cnt   = 0;
    err_cnt   = 0;
    test_name = "reset";
    rst_n     = 1'b0;
    go_idle();
    apply_reset();
    test_name = "cfg_roundtrip";
    repeat (CFG_CYCLES)
    begin
      tick();
      random_stimulus(MODE_CFG);
    end
    test_name = "resp_err";
    repeat (ERR_CYCLES)
    begin
      tick();
      random_stimulus(MODE_ERR);
    end
    test_name = "counters";
    repeat (CNT_CYCLES)
    begin
      tick();
      random_stimulus(MODE_CNT);
    end
    // Profiling on so the freeze after finish shows
    test_name = "finish";
    tick();
    go_idle();
    send_cmd(host_io_pkg::OP_STORE, host_io_pkg::ADDR_PROFILE_EN, 32'h1);
    tick();
    send_cmd(host_io_pkg::OP_STORE, host_io_pkg::ADDR_FINISH, next_rand());
    tick();
    go_idle();
    repeat (FIN_CYCLES)
    begin
      tick();
      random_stimulus(MODE_FIN);
    end
    tick();
    go_idle();
    send_cmd(host_io_pkg::OP_LOAD, host_io_pkg::ADDR_WD_STATUS, '0);
    tick();
    go_idle();
    compare_bit("finish_o after finish store", 1'b1, finish);
    expect_state("wd_status after finish", host_perf_pkg::WD_FINISHED,
                 host_perf_pkg::wd_state_e'(resp_data[1:0]));
    test_name = "stall";
    apply_reset();
    repeat (STALL_CYCLES) tick();
    send_cmd(host_io_pkg::OP_LOAD, host_io_pkg::ADDR_WD_STATUS, '0);
    tick();
    go_idle();
    expect_state("wd_status", host_perf_pkg::WD_STALLED,
                 host_perf_pkg::wd_state_e'(resp_data[1:0]));
    compare_bit("stall_o", 1'b1, stall);
    tick();
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog/host_cfg_regs.sv
`timescale 1ns/1ps

`include "host_params.svh"

module host_cfg_regs
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     trace_we_i,
    input  logic                     profile_we_i,
    input  logic                     finish_we_i,
    input  logic [`HOST_DATA_W-1:0]  wr_data_i,
    output logic [`HOST_TRACE_W-1:0] trace_en_o,
    output logic                     profile_en_o,
    output logic                     finish_o,
    output logic                     pass_o
  );

  logic finish_set;

  // Only the first finish write counts
  assign finish_set = finish_we_i && !finish_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      trace_en_o <= '0;
    end
    else if (trace_we_i)
    begin
      trace_en_o <= wr_data_i[`HOST_TRACE_W-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      profile_en_o <= 1'b0;
    end
    else if (profile_we_i)
    begin
      profile_en_o <= wr_data_i[0];
    end
  end

  // Pass code comes from bit 0 of the finish write
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      finish_o <= 1'b0;
      pass_o   <= 1'b0;
    end
    else if (finish_set)
    begin
      finish_o <= 1'b1;
      pass_o   <= wr_data_i[0];
    end
  end

endmodule

// File: verilog/host_cmd_decode.sv
`timescale 1ns/1ps

`include "host_params.svh"

module host_cmd_decode
  (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           cmd_v_i,
    input  host_io_pkg::host_op_e          cmd_op_i,
    input  host_io_pkg::host_addr_e        cmd_addr_i,
    input  logic [`HOST_DATA_W-1:0]        cmd_data_i,
    input  logic [`HOST_TRACE_W-1:0]       trace_en_i,
    input  logic                           profile_en_i,
    input  logic                           finish_i,
    input  logic                           pass_i,
    input  host_perf_pkg::perf_cnt_t       cycle_cnt_i,
    input  host_perf_pkg::perf_cnt_t       instret_cnt_i,
    input  host_perf_pkg::wd_state_e       wd_state_i,
    output logic                           trace_we_o,
    output logic                           profile_we_o,
    output logic                           finish_we_o,
    output logic [`HOST_DATA_W-1:0]        wr_data_o,
    output logic                           resp_v_o,
    output logic [`HOST_DATA_W-1:0]        resp_data_o,
    output logic                           resp_err_o
  );

  localparam logic [`HOST_ADDR_W-1:0] REG_CNT = `HOST_REG_CNT;

  logic                    is_store;
  logic                    addr_mapped;
  logic                    addr_ro;
  logic                    cmd_err;
  logic [`HOST_DATA_W-1:0] rd_data;

  assign is_store    = (cmd_op_i == host_io_pkg::OP_STORE);
  assign addr_mapped = (cmd_addr_i < REG_CNT);

  // Counters and watchdog status are read only
  assign addr_ro = (cmd_addr_i == host_io_pkg::ADDR_CYCLE_CNT)
                || (cmd_addr_i == host_io_pkg::ADDR_INSTRET_CNT)
                || (cmd_addr_i == host_io_pkg::ADDR_WD_STATUS);

  assign cmd_err = !addr_mapped || (is_store && addr_ro);

  // One strobe per store, only for writable registers
  assign trace_we_o   = cmd_v_i && is_store && (cmd_addr_i == host_io_pkg::ADDR_TRACE_EN);
  assign profile_we_o = cmd_v_i && is_store && (cmd_addr_i == host_io_pkg::ADDR_PROFILE_EN);
  assign finish_we_o  = cmd_v_i && is_store && (cmd_addr_i == host_io_pkg::ADDR_FINISH);
  assign wr_data_o    = cmd_data_i;

  // Load data as seen in the command cycle
  always_comb
  begin
    rd_data = '0;
    case (cmd_addr_i)
      host_io_pkg::ADDR_TRACE_EN:
        rd_data[`HOST_TRACE_W-1:0] = trace_en_i;
      host_io_pkg::ADDR_PROFILE_EN:
        rd_data[0] = profile_en_i;
      host_io_pkg::ADDR_FINISH:
        rd_data[1:0] = {pass_i, finish_i};
      host_io_pkg::ADDR_CYCLE_CNT:
        rd_data = cycle_cnt_i;
      host_io_pkg::ADDR_INSTRET_CNT:
        rd_data = instret_cnt_i;
      host_io_pkg::ADDR_WD_STATUS:
        rd_data[1:0] = wd_state_i;
      default:
        rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_o   <= 1'b0;
      resp_err_o <= 1'b0;
    end
    else
    begin
      resp_v_o   <= cmd_v_i;
      resp_err_o <= cmd_v_i && cmd_err;
    end
  end

  // Stores and errors answer with zero data
  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i)
    begin
      resp_data_o <= (is_store || cmd_err) ? '0 : rd_data;
    end
  end

  a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({trace_we_o, profile_we_o, finish_we_o}));

endmodule

// File: verilog/host_io_pkg.sv
`include "host_params.svh"

package host_io_pkg;

  // Command opcode from the core
  typedef enum logic
  {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } host_op_e;

  // Register map, anything past ADDR_WD_STATUS is unmapped
  typedef enum logic [`HOST_ADDR_W-1:0]
  {
    ADDR_TRACE_EN    = `HOST_ADDR_W'(0),
    ADDR_PROFILE_EN  = `HOST_ADDR_W'(1),
    ADDR_FINISH      = `HOST_ADDR_W'(2),
    ADDR_CYCLE_CNT   = `HOST_ADDR_W'(3),
    ADDR_INSTRET_CNT = `HOST_ADDR_W'(4),
    ADDR_WD_STATUS   = `HOST_ADDR_W'(5)
  } host_addr_e;

endpackage

// File: verilog/host_io_top.sv
`timescale 1ns/1ps

`include "host_params.svh"

module host_io_top
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     cmd_v_i,
    input  host_io_pkg::host_op_e    cmd_op_i,
    input  host_io_pkg::host_addr_e  cmd_addr_i,
    input  logic [`HOST_DATA_W-1:0]  cmd_data_i,
    output logic                     resp_v_o,
    output logic [`HOST_DATA_W-1:0]  resp_data_o,
    output logic                     resp_err_o,
    input  logic                     commit_v_i,
    output logic [`HOST_TRACE_W-1:0] trace_en_o,
    output logic                     profile_en_o,
    output logic                     finish_o,
    output logic                     pass_o,
    output logic                     stall_o
  );

  logic                      trace_we;
  logic                      profile_we;
  logic                      finish_we;
  logic [`HOST_DATA_W-1:0]   wr_data;
  host_perf_pkg::perf_cnt_t  cycle_cnt;
  host_perf_pkg::perf_cnt_t  instret_cnt;
  host_perf_pkg::wd_state_e  wd_state;

  host_cmd_decode host_cmd_decode_inst
    (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cmd_v_i       (cmd_v_i),
      .cmd_op_i      (cmd_op_i),
      .cmd_addr_i    (cmd_addr_i),
      .cmd_data_i    (cmd_data_i),
      .trace_en_i    (trace_en_o),
      .profile_en_i  (profile_en_o),
      .finish_i      (finish_o),
      .pass_i        (pass_o),
      .cycle_cnt_i   (cycle_cnt),
      .instret_cnt_i (instret_cnt),
      .wd_state_i    (wd_state),
      .trace_we_o    (trace_we),
      .profile_we_o  (profile_we),
      .finish_we_o   (finish_we),
      .wr_data_o     (wr_data),
      .resp_v_o      (resp_v_o),
      .resp_data_o   (resp_data_o),
      .resp_err_o    (resp_err_o)
    );

  host_cfg_regs host_cfg_regs_inst
    (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .trace_we_i   (trace_we),
      .profile_we_i (profile_we),
      .finish_we_i  (finish_we),
      .wr_data_i    (wr_data),
      .trace_en_o   (trace_en_o),
      .profile_en_o (profile_en_o),
      .finish_o     (finish_o),
      .pass_o       (pass_o)
    );

  host_perf_counters host_perf_counters_inst
    (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .commit_v_i    (commit_v_i),
      .profile_en_i  (profile_en_o),
      .finish_i      (finish_o),
      .cycle_cnt_o   (cycle_cnt),
      .instret_cnt_o (instret_cnt)
    );

  host_watchdog host_watchdog_inst
    (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .commit_v_i (commit_v_i),
      .finish_i   (finish_o),
      .wd_state_o (wd_state),
      .stall_o    (stall_o)
    );

endmodule

// File: verilog/host_perf_counters.sv
`timescale 1ns/1ps

`include "host_params.svh"

module host_perf_counters
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     commit_v_i,
    input  logic                     profile_en_i,
    input  logic                     finish_i,
    output host_perf_pkg::perf_cnt_t cycle_cnt_o,
    output host_perf_pkg::perf_cnt_t instret_cnt_o
  );

  logic cnt_en;

  // Counting stops for good once the run finishes
  assign cnt_en = profile_en_i && !finish_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cycle_cnt_o <= '0;
    end
    else if (cnt_en)
    begin
      cycle_cnt_o <= cycle_cnt_o + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      instret_cnt_o <= '0;
    end
    else if (cnt_en && commit_v_i)
    begin
      instret_cnt_o <= instret_cnt_o + 1'b1;
    end
  end

  a_cnt_monotonic: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cycle_cnt_o >= $past(cycle_cnt_o)) && (instret_cnt_o >= $past(instret_cnt_o)));

endmodule

// File: verilog/host_perf_pkg.sv
`include "host_params.svh"

package host_perf_pkg;

  // Profile counter value
  typedef logic [`HOST_DATA_W-1:0] perf_cnt_t;

  // Watchdog states, finished and stalled are terminal
  typedef enum logic [1:0]
  {
    WD_ARMED    = 2'd0,
    WD_FINISHED = 2'd1,
    WD_STALLED  = 2'd2
  } wd_state_e;

endpackage

// File: verilog/host_watchdog.sv
`timescale 1ns/1ps

`include "host_params.svh"

module host_watchdog
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     commit_v_i,
    input  logic                     finish_i,
    output host_perf_pkg::wd_state_e wd_state_o,
    output logic                     stall_o
  );

  localparam int IDLE_W = $clog2(`HOST_STALL_LIMIT + 1);
  localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(`HOST_STALL_LIMIT - 1);

  logic [IDLE_W-1:0] idle_cnt;
  logic              trip;

  // Limit is reached on this edge with no commit
  assign trip = (wd_state_o == host_perf_pkg::WD_ARMED) && !finish_i
             && !commit_v_i && (idle_cnt == IDLE_LAST);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wd_state_o <= host_perf_pkg::WD_ARMED;
      idle_cnt   <= '0;
    end
    else
    begin
      case (wd_state_o)
        host_perf_pkg::WD_ARMED:
        begin
          if (finish_i)
          begin
            wd_state_o <= host_perf_pkg::WD_FINISHED;
          end
          else if (commit_v_i)
          begin
            idle_cnt <= '0;
          end
          else
          begin
            idle_cnt <= idle_cnt + 1'b1;
            if (trip)
            begin
              wd_state_o <= host_perf_pkg::WD_STALLED;
            end
          end
        end
        // Terminal states
        default:
          wd_state_o <= wd_state_o;
      endcase
    end
  end

  // Sticky stall flag
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      stall_o <= 1'b0;
    end
    else if (trip)
    begin
      stall_o <= 1'b1;
    end
  end

  a_no_stall_finished: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(stall_o && (wd_state_o == host_perf_pkg::WD_FINISHED)));

endmodule
